// ==== source/rect_pkg.sv ====
//========================================
// Shared types of the remap pipeline
// Fixed-point formats, command fields
// and the pixel tag
//========================================
package rect_pkg;

	// Width of queue address and command count
	localparam int CMD_DEPTH_W = 15;

	// One Y or X entry of the command queue
	typedef logic [17:0] cmd_t;

	// Destination pixel fields
	typedef logic [9:0] xdst_t;
	typedef logic [8:0] ydst_t;
	typedef logic [6:0] len_t;

	// Travels alongside the arithmetic
	typedef struct packed {
		logic  valid;
		logic  last;
		xdst_t xdst;
		ydst_t ydst;
		len_t  len;
	} pix_tag_t;

	// Working value in signed Q1.24
	typedef logic signed [25:0] fix_t;
	// lx and ly held together through the divider delay
	typedef fix_t [1:0] fix_pair_t;
	// Matrix coefficient in signed Q0.24
	typedef logic signed [24:0] coef_t;
	// Inverse focal length scaled by 2^-32
	typedef logic [23:0] inv_focal_t;
	// Centre over focal length in Q0.24
	typedef logic [23:0] ofs_t;
	// Focal length in Q10.16
	typedef logic [25:0] focal_t;
	// Source coordinates in Q10.5 and Q9.5
	typedef logic [14:0] xsrc_t;
	typedef logic [13:0] ysrc_t;

endpackage

// ==== source/rect_cmd_queue.sv ====
//========================================
// Command queue
// Inferred RAM, write addressing, count
// and cyclic run-mode read port
//========================================
`timescale 1ns/1ps

module rect_cmd_queue (
	input  logic                             clk,
	input  logic                             rst_n,
	input  logic                             en_i,
	input  logic                             run_i,
	input  logic                             cmd_wr_i,
	input  logic                             cmd_clr_i,
	input  rect_pkg::cmd_t                   cmd_i,
	output logic [rect_pkg::CMD_DEPTH_W-1:0] cmd_count_o,
	output rect_pkg::cmd_t                   cmd_data_o,
	output logic                             cmd_valid_o,
	output logic                             cmd_last_o,
	input  logic                             cmd_ready_i
);
	import rect_pkg::*;

	cmd_t mem [2**CMD_DEPTH_W];
	logic [CMD_DEPTH_W-1:0] addr_q;
	logic [CMD_DEPTH_W-1:0] wr_addr;
	logic run_q;
	logic mode_chg;
	logic wr_en;
	logic fetch;
	logic fetch_last;

	// Any edge on run_i restarts at address zero
	assign mode_chg = (run_i != run_q);
	// First write after a mode change lands on zero
	assign wr_addr = mode_chg ? '0 : addr_q;
	assign wr_en = !run_i && cmd_wr_i && !cmd_clr_i;

	// Fetch when empty or when the held word is taken
	assign fetch = run_i && !mode_chg && (cmd_count_o != '0) &&
		(!cmd_valid_o || (cmd_ready_i && en_i));
	// Final stored word, wrap afterwards
	assign fetch_last = (addr_q + 1'b1 == cmd_count_o);

	//========================================
	// Address and count
	//========================================
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			run_q <= 1'b0;
			addr_q <= '0;
			cmd_count_o <= '0;
		end else begin
			run_q <= run_i;
			if (!run_i && cmd_clr_i) begin
				addr_q <= '0;
				cmd_count_o <= '0;
			end else if (wr_en) begin
				addr_q <= wr_addr + 1'b1;
				cmd_count_o <= cmd_count_o + 1'b1;
			end else if (mode_chg) begin
				addr_q <= '0;
			end else if (fetch) begin
				addr_q <= fetch_last ? '0 : addr_q + 1'b1;
			end
		end
	end

	// RAM with one cycle of read latency
	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_addr] <= cmd_i;
		end
		if (fetch) begin
			cmd_data_o <= mem[addr_q];
		end
	end

	// Word status follows the read
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cmd_valid_o <= 1'b0;
			cmd_last_o <= 1'b0;
		end else if (!run_i || mode_chg) begin
			cmd_valid_o <= 1'b0;
		end else if (fetch) begin
			cmd_valid_o <= 1'b1;
			cmd_last_o <= fetch_last;
		end
	end

endmodule

// ==== source/rect_run_decoder.sv ====
//========================================
// Run decoder
// Y and X commands to destination pixels
//========================================
`timescale 1ns/1ps

module rect_run_decoder (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               en_i,
	input  rect_pkg::cmd_t     cmd_data_i,
	input  logic               cmd_valid_i,
	input  logic               cmd_last_i,
	output logic               cmd_ready_o,
	output rect_pkg::pix_tag_t tag_o
);
	import rect_pkg::*;

	ydst_t row_q;
	xdst_t col_q;
	len_t len_q;
	len_t rem_q;
	logic last_run_q;
	logic accept;
	logic is_y;

	// Next command only once the current run is empty
	assign cmd_ready_o = (rem_q == '0);
	assign accept = cmd_valid_i && cmd_ready_o && en_i;
	// Zero length field marks a Y command
	assign is_y = (cmd_data_i[6:0] == '0);

	//========================================
	// Run state
	//========================================
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			row_q <= '0;
			col_q <= '0;
			len_q <= '0;
			rem_q <= '0;
			last_run_q <= 1'b0;
		end else if (accept) begin
			if (is_y) begin
				// Row in bits 16..8
				row_q <= cmd_data_i[16:8];
			end else begin
				// ydif bumps the row by one
				row_q <= row_q + ydst_t'(cmd_data_i[7]);
				col_q <= cmd_data_i[17:8];
				len_q <= cmd_data_i[6:0];
				rem_q <= cmd_data_i[6:0];
				last_run_q <= cmd_last_i;
			end
		end else if (en_i && (rem_q != '0)) begin
			col_q <= col_q + 1'b1;
			rem_q <= rem_q - 1'b1;
		end
	end

	// One pixel per advancing cycle
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			tag_o <= '0;
		end else if (en_i) begin
			tag_o.valid <= (rem_q != '0);
			// Final pixel of a run from the last word
			tag_o.last <= last_run_q && (rem_q == len_t'(1));
			tag_o.xdst <= col_q;
			tag_o.ydst <= row_q;
			tag_o.len <= len_q;
		end
	end

endmodule

// ==== source/rect_proj_rotate.sv ====
//========================================
// Normalisation and 3x3 rotation
// Four stages with the tag alongside
//========================================
`timescale 1ns/1ps

module rect_proj_rotate (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 en_i,
	input  rect_pkg::pix_tag_t   tag_i,
	input  rect_pkg::inv_focal_t inv_fx_i, inv_fy_i,
	input  rect_pkg::ofs_t       cx_f_i, cy_f_i,
	input  rect_pkg::coef_t      r11_i, r12_i, r13_i,
	input  rect_pkg::coef_t      r21_i, r22_i, r23_i,
	input  rect_pkg::coef_t      r31_i, r32_i, r33_i,
	output rect_pkg::fix_t       lx_o, ly_o, lw_o,
	output rect_pkg::pix_tag_t   tag_o
);
	import rect_pkg::*;

	fix_t xn_q, yn_q;
	fix_t xd_q, yd_q;
	fix_t m11_q, m21_q, m12_q, m22_q, m13_q, m23_q;
	logic [33:0] xn_p, yn_p;
	logic signed [50:0] p11, p21, p12, p22, p13, p23;
	logic signed [27:0] sx, sy, sw;
	pix_tag_t tag_q [4];

	// u10.0 times u-8.32 gives u2.32
	assign xn_p = tag_i.xdst * inv_fx_i;
	assign yn_p = tag_i.ydst * inv_fy_i;

	// s0.24 times s1.24 gives s2.48
	assign p11 = r11_i * xd_q;
	assign p21 = r21_i * yd_q;
	assign p12 = r12_i * xd_q;
	assign p22 = r22_i * yd_q;
	assign p13 = r13_i * xd_q;
	assign p23 = r23_i * yd_q;

	// Row sums with the third row as offset
	assign sx = m11_q + m21_q + r31_i;
	assign sy = m12_q + m22_q + r32_i;
	assign sw = m13_q + m23_q + r33_i;

	//========================================
	// Arithmetic stages
	//========================================
	always_ff @(posedge clk) begin
		if (en_i) begin
			// Stage 1, truncate to Q1.24
			xn_q <= {1'b0, xn_p[32:8]};
			yn_q <= {1'b0, yn_p[32:8]};
			// Stage 2, centre offset
			xd_q <= xn_q - fix_t'({2'b00, cx_f_i});
			yd_q <= yn_q - fix_t'({2'b00, cy_f_i});
			// Stage 3, products back to Q1.24
			m11_q <= p11[49:24];
			m21_q <= p21[49:24];
			m12_q <= p12[49:24];
			m22_q <= p22[49:24];
			m13_q <= p13[49:24];
			m23_q <= p23[49:24];
			// Stage 4, sign plus low 25 bits
			lx_o <= {sx[27], sx[24:0]};
			ly_o <= {sy[27], sy[24:0]};
			lw_o <= {sw[27], sw[24:0]};
		end
	end

	// Tag follows all four stages
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			tag_q <= '{default: '0};
		end else if (en_i) begin
			tag_q <= '{tag_i, tag_q[0], tag_q[1], tag_q[2]};
		end
	end

	assign tag_o = tag_q[3];

endmodule

// ==== source/rect_recip_div.sv ====
//========================================
// Pipelined restoring divider for 1/w
//========================================
`timescale 1ns/1ps

module rect_recip_div #(
	// Quotient bits, one stage each, 22 to 26
	parameter int DIV_STAGES = 26
) (
	input  logic           clk,
	input  logic           rst_n,
	input  logic           en_i,
	input  rect_pkg::fix_t divisor_i,
	output rect_pkg::fix_t quotient_o
);
	import rect_pkg::*;

	localparam int FRAC = 24;
	localparam int REM_W = 27;
	// Dividend bits above the first quotient bit
	localparam logic [REM_W-1:0] REM_INIT = REM_W'(1) << (2 * FRAC - DIV_STAGES);
	// Largest positive Q1.24
	localparam fix_t QMAX = {1'b0, {25{1'b1}}};

	logic signed [REM_W-1:0] wide;
	logic [REM_W-1:0] mag;
	logic [REM_W-1:0] den_q [DIV_STAGES];
	logic [REM_W-1:0] rem_q [DIV_STAGES];
	logic [REM_W-1:0] shift_c [DIV_STAGES];
	logic [DIV_STAGES-1:0] fit_c;
	logic [DIV_STAGES-1:0] quo_q [DIV_STAGES];
	logic [DIV_STAGES:0] neg_q, sat_q;
	fix_t quo_mag;

	assign wide = divisor_i;
	assign mag = wide[REM_W-1] ? -wide : wide;

	// Trial subtract per stage
	always_comb begin
		for (int k = 0; k < DIV_STAGES; k++) begin
			shift_c[k] = {rem_q[k][REM_W-2:0], 1'b0};
			fit_c[k] = (shift_c[k] >= den_q[k]);
		end
	end

	//========================================
	// Remainder and quotient stages
	//========================================
	always_ff @(posedge clk) begin
		if (en_i) begin
			den_q[0] <= mag;
			rem_q[0] <= REM_INIT;
			for (int k = 1; k < DIV_STAGES; k++) begin
				den_q[k] <= den_q[k-1];
				rem_q[k] <= fit_c[k-1] ? shift_c[k-1] - den_q[k-1] : shift_c[k-1];
			end
			// MSB first
			quo_q[0] <= DIV_STAGES'(fit_c[0]);
			for (int k = 1; k < DIV_STAGES; k++) begin
				quo_q[k] <= {quo_q[k-1][DIV_STAGES-2:0], fit_c[k]};
			end
		end
	end

	// Sign and overflow carried down with the data
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			neg_q <= '0;
			sat_q <= '0;
		end else if (en_i) begin
			neg_q <= {neg_q[DIV_STAGES-1:0], divisor_i[25]};
			// Quotient too large for the stage count
			sat_q <= {sat_q[DIV_STAGES-1:0], (mag <= REM_INIT)};
		end
	end

	// Clamp to Q1.24 range, then restore the sign
	assign quo_mag = (sat_q[DIV_STAGES] || (32'(quo_q[DIV_STAGES-1]) > 32'(QMAX))) ?
		QMAX : fix_t'(quo_q[DIV_STAGES-1]);
	assign quotient_o = neg_q[DIV_STAGES] ? -quo_mag : quo_mag;

endmodule

// ==== source/rect_delay_line.sv ====
//========================================
// Enable-gated shift register
//========================================
`timescale 1ns/1ps

module rect_delay_line #(
	parameter int DEPTH = 2,
	parameter type payload_t = logic
) (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     en_i,
	input  payload_t data_i,
	output payload_t data_o
);

	payload_t pipe_q [DEPTH];

	// Holds position under back-pressure
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pipe_q <= '{default: '0};
		end else if (en_i) begin
			pipe_q[0] <= data_i;
			for (int i = 1; i < DEPTH; i++) begin
				pipe_q[i] <= pipe_q[i-1];
			end
		end
	end

	assign data_o = pipe_q[DEPTH-1];

endmodule

// ==== source/rect_src_scale.sv ====
//========================================
// Perspective multiply, focal scaling,
// centre add and rounding to 1/32 pixel
//========================================
`timescale 1ns/1ps

module rect_src_scale (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               en_i,
	input  rect_pkg::fix_t     lx_i, ly_i, inv_w_i,
	input  rect_pkg::pix_tag_t tag_i,
	input  rect_pkg::focal_t   fx_i, fy_i,
	input  rect_pkg::xdst_t    cx_i,
	input  rect_pkg::ydst_t    cy_i,
	output rect_pkg::xsrc_t    xsrc_o,
	output rect_pkg::ysrc_t    ysrc_o,
	output rect_pkg::pix_tag_t tag_o
);
	import rect_pkg::*;

	fix_t lx_q, ly_q, inv_w_q;
	fix_t x2_q, y2_q;
	logic signed [16:0] xf_q, yf_q;
	logic signed [51:0] x2_p, y2_p;
	logic signed [52:0] xf_p, yf_p;
	logic signed [17:0] xc, yc;
	logic [15:0] x_rnd;
	logic [14:0] y_rnd;
	pix_tag_t tag_q [4];

	// s1.24 times s1.24 gives s2.48
	assign x2_p = lx_q * inv_w_q;
	assign y2_p = ly_q * inv_w_q;

	// s1.24 times u10.16 gives s11.40
	assign xf_p = x2_q * $signed({1'b0, fx_i});
	assign yf_p = y2_q * $signed({1'b0, fy_i});

	// Centre moved to six fraction bits
	assign xc = xf_q + $signed({1'b0, cx_i, 6'b0});
	assign yc = yf_q + $signed({1'b0, cy_i, 6'b0});
	// Half up at the 1/64 bit
	assign x_rnd = xc[15:0] + 16'd1;
	assign y_rnd = yc[14:0] + 15'd1;

	//========================================
	// Arithmetic stages
	//========================================
	always_ff @(posedge clk) begin
		if (en_i) begin
			// Stage 1 aligns 1/w with the delayed numerators
			lx_q <= lx_i;
			ly_q <= ly_i;
			inv_w_q <= inv_w_i;
			// Stage 2 back to Q1.24
			x2_q <= {x2_p[51], x2_p[48:24]};
			y2_q <= {y2_p[51], y2_p[48:24]};
			// Stage 3 down to s10.6
			xf_q <= {xf_p[52], xf_p[49:34]};
			yf_q <= {yf_p[52], yf_p[49:34]};
			// Stage 4 drops the 1/64 bit
			xsrc_o <= x_rnd[15:1];
			ysrc_o <= y_rnd[14:1];
		end
	end

	// Tag follows all four stages
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			tag_q <= '{default: '0};
		end else if (en_i) begin
			tag_q <= '{tag_i, tag_q[0], tag_q[1], tag_q[2]};
		end
	end

	assign tag_o = tag_q[3];

endmodule

// ==== source/rect_remap.sv ====
//========================================
// Remap coordinate generator top level
// Queue, decoder, pipeline and output
//========================================
`timescale 1ns/1ps

module rect_remap #(
	parameter int DIV_STAGES = 26
) (
	input  logic                             clk,
	input  logic                             rst_n,
	// Host command port
	input  logic                             run_i,
	input  logic                             cmd_wr_i,
	input  logic                             cmd_clr_i,
	input  rect_pkg::cmd_t                   cmd_i,
	output logic [rect_pkg::CMD_DEPTH_W-1:0] cmd_count_o,
	// Camera parameters
	input  rect_pkg::focal_t                 fx_i, fy_i,
	input  rect_pkg::xdst_t                  cx_i,
	input  rect_pkg::ydst_t                  cy_i,
	input  rect_pkg::inv_focal_t             inv_fx_i, inv_fy_i,
	input  rect_pkg::ofs_t                   cx_f_i, cy_f_i,
	input  rect_pkg::coef_t                  r11_i, r12_i, r13_i,
	input  rect_pkg::coef_t                  r21_i, r22_i, r23_i,
	input  rect_pkg::coef_t                  r31_i, r32_i, r33_i,
	// Pixel output
	input  logic                             out_ready_i,
	output logic                             out_valid_o,
	output logic                             last_o,
	output rect_pkg::xdst_t                  xdst_o,
	output rect_pkg::ydst_t                  ydst_o,
	output rect_pkg::len_t                   len_o,
	output rect_pkg::xsrc_t                  xsrc_o,
	output rect_pkg::ysrc_t                  ysrc_o
);
	import rect_pkg::*;

	logic adv;
	cmd_t q_data;
	logic q_valid, q_last, q_ready;
	pix_tag_t dec_tag, rot_tag, dly_tag, out_tag;
	fix_t lx, ly, lw, inv_w;
	fix_pair_t lxy_in, lxy_dly;

	// Stall everything while an output waits
	assign adv = !out_valid_o || out_ready_i;

	rect_cmd_queue rect_cmd_queue_inst (
		.clk(clk), .rst_n(rst_n), .en_i(adv),
		.run_i(run_i), .cmd_wr_i(cmd_wr_i), .cmd_clr_i(cmd_clr_i),
		.cmd_i(cmd_i), .cmd_count_o(cmd_count_o),
		.cmd_data_o(q_data), .cmd_valid_o(q_valid),
		.cmd_last_o(q_last), .cmd_ready_i(q_ready)
	);

	rect_run_decoder rect_run_decoder_inst (
		.clk(clk), .rst_n(rst_n), .en_i(adv),
		.cmd_data_i(q_data), .cmd_valid_i(q_valid),
		.cmd_last_i(q_last), .cmd_ready_o(q_ready),
		.tag_o(dec_tag)
	);

	//========================================
	// Coordinate pipeline
	//========================================
	rect_proj_rotate rect_proj_rotate_inst (
		.clk(clk), .rst_n(rst_n), .en_i(adv), .tag_i(dec_tag),
		.inv_fx_i(inv_fx_i), .inv_fy_i(inv_fy_i),
		.cx_f_i(cx_f_i), .cy_f_i(cy_f_i),
		.r11_i(r11_i), .r12_i(r12_i), .r13_i(r13_i),
		.r21_i(r21_i), .r22_i(r22_i), .r23_i(r23_i),
		.r31_i(r31_i), .r32_i(r32_i), .r33_i(r33_i),
		.lx_o(lx), .ly_o(ly), .lw_o(lw), .tag_o(rot_tag)
	);

	rect_recip_div #(.DIV_STAGES(DIV_STAGES)) rect_recip_div_inst (
		.clk(clk), .rst_n(rst_n), .en_i(adv),
		.divisor_i(lw), .quotient_o(inv_w)
	);

	// Numerators and tag wait out the divider
	assign lxy_in[1] = lx;
	assign lxy_in[0] = ly;

	rect_delay_line #(.DEPTH(DIV_STAGES + 1), .payload_t(fix_pair_t)) lxy_delay_inst (
		.clk(clk), .rst_n(rst_n), .en_i(adv),
		.data_i(lxy_in), .data_o(lxy_dly)
	);

	rect_delay_line #(.DEPTH(DIV_STAGES + 1), .payload_t(pix_tag_t)) tag_delay_inst (
		.clk(clk), .rst_n(rst_n), .en_i(adv),
		.data_i(rot_tag), .data_o(dly_tag)
	);

	rect_src_scale rect_src_scale_inst (
		.clk(clk), .rst_n(rst_n), .en_i(adv),
		.lx_i(lxy_dly[1]), .ly_i(lxy_dly[0]), .inv_w_i(inv_w),
		.tag_i(dly_tag), .fx_i(fx_i), .fy_i(fy_i),
		.cx_i(cx_i), .cy_i(cy_i),
		.xsrc_o(xsrc_o), .ysrc_o(ysrc_o), .tag_o(out_tag)
	);

	// Final tag drives the handshake and the destination fields
	assign out_valid_o = out_tag.valid;
	assign last_o = out_tag.last;
	assign xdst_o = out_tag.xdst;
	assign ydst_o = out_tag.ydst;
	assign len_o = out_tag.len;

endmodule

// ==== tests/rect_remap_checker.sv ====
//========================================
// Concurrent assertions on the remap top
// Output handshake, reset state, count
//========================================
`timescale 1ns/1ps

module rect_remap_checker (
	input  logic                             clk,
	input  logic                             rst_n,
	input  logic                             run_i,
	input  logic [rect_pkg::CMD_DEPTH_W-1:0] cmd_count_i,
	input  logic                             out_ready_i,
	input  logic                             out_valid_i,
	input  logic                             last_i,
	input  rect_pkg::xdst_t                  xdst_i,
	input  rect_pkg::ydst_t                  ydst_i,
	input  rect_pkg::len_t                   len_i,
	input  rect_pkg::xsrc_t                  xsrc_i,
	input  rect_pkg::ysrc_t                  ysrc_i
);

	// Read by the testbench at the end
	int unsigned fail_count = 0;

	// Output idle straight after reset
	reset_idle: assert property (@(posedge clk) !rst_n |=> !out_valid_i)
		else begin
			$error("out_valid_o high after reset");
			fail_count++;
		end

	//========================================
	// Output handshake
	//========================================
	// Stalled pixel stays put until taken
	hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
		(out_valid_i && !out_ready_i) |=> (out_valid_i && $stable(last_i) &&
		$stable(xdst_i) && $stable(ydst_i) && $stable(len_i) &&
		$stable(xsrc_i) && $stable(ysrc_i)))
		else begin
			$error("output changed while stalled");
			fail_count++;
		end

	// No writes land in run mode
	count_frozen: assert property (@(posedge clk) disable iff (!rst_n)
		run_i |=> $stable(cmd_count_i))
		else begin
			$error("cmd_count_o changed in run mode");
			fail_count++;
		end

endmodule

// ==== tests/tb_rect_remap.sv ====
//========================================
// Testbench for the remap generator
// Stimulus table, pixel model, checks
// and watchdog
//========================================
`timescale 1ns/1ps

module tb_rect_remap;
	import rect_pkg::*;

	localparam int DIV_STAGES = 26;
	localparam int RST_CYCLES = 16;
	// Each command list is expanded twice to cover the wrap
	localparam int PASSES = 2;
	// Longer than the full pipeline latency
	localparam int QUIET_CYCLES = DIV_STAGES + 16;
	// Q0.24 coefficients
	localparam int HALF = 1 << 23;
	localparam int QUARTER = 1 << 22;
	localparam int TOL = 2;

	logic clk;
	logic rst_n;
	logic run_i, cmd_wr_i, cmd_clr_i;
	cmd_t cmd_i;
	logic [CMD_DEPTH_W-1:0] cmd_count_o;
	focal_t fx_i, fy_i;
	xdst_t cx_i;
	ydst_t cy_i;
	inv_focal_t inv_fx_i, inv_fy_i;
	ofs_t cx_f_i, cy_f_i;
	coef_t r11_i, r12_i, r13_i, r21_i, r22_i, r23_i, r31_i, r32_i, r33_i;
	logic out_ready_i, out_valid_o, last_o;
	xdst_t xdst_o;
	ydst_t ydst_o;
	len_t len_o;
	xsrc_t xsrc_o;
	ysrc_t ysrc_o;

	// Stimulus table, one entry per parameter set
	int t_focal [$], t_cx [$], t_cy [$];
	int t_r11 [$], t_r22 [$], t_r33 [$];
	int t_rand [$], t_first [$], t_count [$];
	// Command fields, kind 0 is Y and 1 is X
	int c_kind [$], c_pos [$], c_ydif [$], c_len [$];
	// Expected pixel stream
	int exp_x [$], exp_y [$], exp_len [$], exp_last [$];

	int checks = 0;
	int errors = 0;
	int exp_count = 0;
	int wd_cycles = 0;

	rect_remap #(.DIV_STAGES(DIV_STAGES)) rect_remap_inst (.*);

	bind rect_remap rect_remap_checker rect_remap_checker_inst (
		.clk(clk), .rst_n(rst_n), .run_i(run_i), .cmd_count_i(cmd_count_o),
		.out_ready_i(out_ready_i), .out_valid_i(out_valid_o), .last_i(last_o),
		.xdst_i(xdst_o), .ydst_i(ydst_o), .len_i(len_o),
		.xsrc_i(xsrc_o), .ysrc_i(ysrc_o)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	//========================================
	// Table and model
	//========================================
	task automatic add_test(int focal, int cx, int cy, int r11, int r22, int r33, int rnd);
		t_focal.push_back(focal);
		t_cx.push_back(cx);
		t_cy.push_back(cy);
		t_r11.push_back(r11);
		t_r22.push_back(r22);
		t_r33.push_back(r33);
		t_rand.push_back(rnd);
		t_first.push_back(c_kind.size());
		t_count.push_back(0);
	endtask

	task automatic add_cmd(int kind, int pos, int ydif, int len);
		c_kind.push_back(kind);
		c_pos.push_back(pos);
		c_ydif.push_back(ydif);
		c_len.push_back(len);
		t_count[t_count.size()-1] = t_count[t_count.size()-1] + 1;
	endtask

	task automatic load_table;
		// Neutral map, always ready
		add_test(512, 320, 240, HALF, HALF, HALF, 0);
		add_cmd(0, 100, 0, 0);
		add_cmd(1, 200, 0, 5);
		add_cmd(1, 300, 1, 3);
		add_cmd(1, 250, 0, 4);
		// Half zoom, two rows set by Y
		add_test(512, 320, 240, QUARTER, QUARTER, HALF, 0);
		add_cmd(0, 60, 0, 0);
		add_cmd(1, 120, 0, 6);
		add_cmd(0, 300, 0, 0);
		add_cmd(1, 500, 1, 2);
		// Back-pressure cases
		add_test(512, 320, 240, HALF, HALF, HALF, 1);
		add_cmd(0, 400, 0, 0);
		add_cmd(1, 600, 1, 7);
		add_cmd(1, 100, 1, 1);
		add_test(512, 320, 240, QUARTER, QUARTER, HALF, 1);
		add_cmd(0, 10, 0, 0);
		add_cmd(1, 10, 0, 20);
		add_cmd(1, 630, 1, 4);
	endtask

	function automatic cmd_t y_word(int row);
		return {1'b0, row[8:0], 8'h00};
	endfunction

	function automatic cmd_t x_word(int col, int ydif, int len);
		return {col[9:0], ydif[0], len[6:0]};
	endfunction

	// Source in 1/32 pixel: centre plus scaled offset
	function automatic int ideal_src(int dst, int centre, int r_num, int r_den);
		real pos;
		pos = real'(centre) + real'(dst - centre) * real'(r_num) / real'(r_den);
		return $rtoi(pos * 32.0 + 0.5);
	endfunction

	task automatic build_expected(int t);
		int row;
		int last_cmd;
		int c;
		exp_x.delete();
		exp_y.delete();
		exp_len.delete();
		exp_last.delete();
		row = 0;
		last_cmd = t_first[t] + t_count[t] - 1;
		for (int p = 0; p < PASSES; p++) begin
			for (int i = 0; i < t_count[t]; i++) begin
				c = t_first[t] + i;
				if (c_kind[c] == 0) begin
					row = c_pos[c];
				end else begin
					// Row steps by ydif, 9-bit wrap
					row = (row + c_ydif[c]) % 512;
					for (int k = 0; k < c_len[c]; k++) begin
						exp_x.push_back(c_pos[c] + k);
						exp_y.push_back(row);
						exp_len.push_back(c_len[c]);
						exp_last.push_back((c == last_cmd && k == c_len[c] - 1) ? 1 : 0);
					end
				end
			end
		end
	endtask

	//========================================
	// Checks and drivers
	//========================================
	task automatic check_eq(string name, int got, int exp);
		checks++;
		if (got != exp) begin
			errors++;
			$display("[ERROR] t=%0t %s got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic check_near(string name, int got, int exp);
		checks++;
		if (got > exp + TOL || got < exp - TOL) begin
			errors++;
			$display("[ERROR] t=%0t %s got %0d expected %0d +/- %0d",
				$time, name, got, exp, TOL);
		end
	endtask

	task automatic apply_params(int t);
		longint f;
		f = t_focal[t];
		@(negedge clk);
		fx_i = focal_t'(f << 16);
		fy_i = focal_t'(f << 16);
		inv_fx_i = inv_focal_t'((longint'(1) << 32) / f);
		inv_fy_i = inv_focal_t'((longint'(1) << 32) / f);
		cx_f_i = ofs_t'((longint'(t_cx[t]) << 24) / f);
		cy_f_i = ofs_t'((longint'(t_cy[t]) << 24) / f);
		cx_i = xdst_t'(t_cx[t]);
		cy_i = ydst_t'(t_cy[t]);
		r11_i = coef_t'(t_r11[t]);
		r22_i = coef_t'(t_r22[t]);
		r33_i = coef_t'(t_r33[t]);
	endtask

	task automatic write_word(cmd_t word);
		@(negedge clk);
		cmd_i = word;
		cmd_wr_i = 1'b1;
		@(negedge clk);
		cmd_wr_i = 1'b0;
		exp_count++;
		check_eq("cmd_count_o", cmd_count_o, exp_count);
	endtask

	task automatic clear_queue;
		@(negedge clk);
		cmd_clr_i = 1'b1;
		@(negedge clk);
		cmd_clr_i = 1'b0;
		exp_count = 0;
		check_eq("cmd_count_o", cmd_count_o, exp_count);
	endtask

	// Write and clear strobes in run mode leave the queue alone
	task automatic strobe_during_run;
		@(negedge clk);
		cmd_i = x_word(0, 0, 1);
		cmd_wr_i = 1'b1;
		@(negedge clk);
		cmd_wr_i = 1'b0;
		cmd_clr_i = 1'b1;
		@(negedge clk);
		cmd_clr_i = 1'b0;
		check_eq("cmd_count_o", cmd_count_o, exp_count);
	endtask

	// Compare each pixel as it is taken
	task automatic run_and_check(int t);
		int idx;
		idx = 0;
		@(negedge clk);
		run_i = 1'b1;
		// Well ahead of the first output pixel
		strobe_during_run();
		while (idx < exp_x.size()) begin
			@(negedge clk);
			if (t_rand[t] != 0) begin
				out_ready_i = ($urandom % 2 == 1);
			end else begin
				out_ready_i = 1'b1;
			end
			// Outputs here hold until the next rising edge
			if (out_valid_o && out_ready_i) begin
				check_eq("xdst_o", xdst_o, exp_x[idx]);
				check_eq("ydst_o", ydst_o, exp_y[idx]);
				check_eq("len_o", len_o, exp_len[idx]);
				check_eq("last_o", last_o, exp_last[idx]);
				check_near("xsrc_o", xsrc_o, ideal_src(exp_x[idx], t_cx[t], t_r11[t], t_r33[t]));
				check_near("ysrc_o", ysrc_o, ideal_src(exp_y[idx], t_cy[t], t_r22[t], t_r33[t]));
				idx++;
			end
		end
	endtask

	// Stop the queue and let the tail run out
	task automatic drain_pipeline;
		int quiet;
		@(negedge clk);
		run_i = 1'b0;
		out_ready_i = 1'b1;
		quiet = 0;
		while (quiet < QUIET_CYCLES) begin
			@(negedge clk);
			if (out_valid_o) begin
				quiet = 0;
			end else begin
				quiet++;
			end
		end
	endtask

	task automatic run_test(int t);
		apply_params(t);
		// Stray word, removed by the clear
		write_word(x_word(0, 0, 1));
		clear_queue();
		for (int i = 0; i < t_count[t]; i++) begin
			if (c_kind[t_first[t] + i] == 0) begin
				write_word(y_word(c_pos[t_first[t] + i]));
			end else begin
				write_word(x_word(c_pos[t_first[t] + i], c_ydif[t_first[t] + i],
					c_len[t_first[t] + i]));
			end
		end
		build_expected(t);
		run_and_check(t);
		drain_pipeline();
	endtask

	//========================================
	// Main sequence
	//========================================
	initial begin
		int total;
		rst_n = 1'b0;
		run_i = 1'b0;
		cmd_wr_i = 1'b0;
		cmd_clr_i = 1'b0;
		cmd_i = '0;
		fx_i = '0;
		fy_i = '0;
		cx_i = '0;
		cy_i = '0;
		inv_fx_i = '0;
		inv_fy_i = '0;
		cx_f_i = '0;
		cy_f_i = '0;
		r11_i = '0;
		r12_i = '0;
		r13_i = '0;
		r21_i = '0;
		r22_i = '0;
		r23_i = '0;
		r31_i = '0;
		r32_i = '0;
		r33_i = '0;
		out_ready_i = 1'b1;
		void'($urandom(53663));
		load_table();
		total = 0;
		for (int c = 0; c < c_len.size(); c++) begin
			total = total + PASSES * c_len[c];
		end
		wd_cycles = 200 * total + RST_CYCLES;
		repeat (RST_CYCLES) @(negedge clk);
		rst_n = 1'b1;
		check_eq("out_valid_o", out_valid_o, 0);
		check_eq("cmd_count_o", cmd_count_o, 0);
		for (int t = 0; t < t_focal.size(); t++) begin
			run_test(t);
		end
		errors = errors + rect_remap_inst.rect_remap_checker_inst.fail_count;
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

	// Watchdog sized from the expected pixel count
	initial begin
		wait (wd_cycles > 0);
		repeat (wd_cycles) @(posedge clk);
		$display("Timeout, the run did not finish within %0d cycles", wd_cycles);
		$display("Checks: %0d, errors: %0d", checks, errors);
		$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

// ==== build.f ====
source/rect_pkg.sv
source/rect_cmd_queue.sv
source/rect_run_decoder.sv
source/rect_proj_rotate.sv
source/rect_recip_div.sv
source/rect_delay_line.sv
source/rect_src_scale.sv
source/rect_remap.sv
tests/rect_remap_checker.sv
tests/tb_rect_remap.sv

// ==== Makefile ====
# Verilator build and run of the remap testbench

SIM      = verilator
TOP      = tb_rect_remap
FILELIST = build.f
FLAGS    = --binary --timing --assert -Wno-fatal --top-module $(TOP)
BUILD    = obj_dir
LOG      = sim.log
PASS_MSG = ALL TESTS PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the simulation, pass if the log holds the pass line"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
